/* verilog/alpha_lite_settings.svh */
////////////////////////////////////////////////////////////
// Fixed widths and register constants for the Alpha
// subset core. Every value here is set by the ISA.
// Included by the ISA package, the interfaces, each RTL
// module and the testbench
////////////////////////////////////////////////////////////

`ifndef ALPHA_LITE_SETTINGS_SVH
`define ALPHA_LITE_SETTINGS_SVH

// Datapath
`define ALPHA_XLEN      64  // Integer register and ALU width
`define ALPHA_INST_W    32  // One operate-format instruction word

// Register file
`define ALPHA_IDX_W     5   // ra / rb / rc field width
`define ALPHA_NUM_REGS  32  // r0 .. r31
`define ALPHA_ZERO_REG  31  // Reads zero, writes dropped

`endif

/* verilog/isa_pkg.sv */
////////////////////////////////////////////////////////////
// Alpha operate-format instruction layout and codes.
// Decode views one word through alpha_inst_u, either as
// register form or as literal form
////////////////////////////////////////////////////////////

`default_nettype none
`include "alpha_lite_settings.svh"

package isa_pkg;

  localparam int LIT_W = 8;  // Zero-extended operand B literal

  // Register form, bit 12 clear
  typedef struct packed {
    logic [5:0]              opcode;  // 31:26
    logic [`ALPHA_IDX_W-1:0] ra;      // 25:21
    logic [`ALPHA_IDX_W-1:0] rb;      // 20:16
    logic [2:0]              sbz;     // 15:13 should be zero
    logic                    is_lit;  // 12
    logic [6:0]              func;    // 11:5
    logic [`ALPHA_IDX_W-1:0] rc;      // 4:0
  } op_fields_t;

  // Literal form, bits 20:13 hold the constant
  typedef struct packed {
    logic [5:0]              opcode;
    logic [`ALPHA_IDX_W-1:0] ra;
    logic [LIT_W-1:0]        lit;
    logic                    is_lit;
    logic [6:0]              func;
    logic [`ALPHA_IDX_W-1:0] rc;
  } lit_fields_t;

  typedef union packed {
    op_fields_t  reg_form;
    lit_fields_t lit_form;
  } alpha_inst_u;

  typedef enum logic [5:0] {
    INTA = 6'h10,  // Integer arithmetic
    INTL = 6'h11,  // Integer logical
    INTS = 6'h12   // Integer shift
  } opcode_e;

  // Function codes repeat across opcodes (ADDQ and BIS are both 0x20)
  typedef logic [6:0] func_e;
  localparam func_e FUNC_ADDQ   = 7'h20;  // INTA
  localparam func_e FUNC_SUBQ   = 7'h29;
  localparam func_e FUNC_CMPEQ  = 7'h2d;
  localparam func_e FUNC_CMPULT = 7'h1d;
  localparam func_e FUNC_AND    = 7'h00;  // INTL
  localparam func_e FUNC_BIS    = 7'h20;
  localparam func_e FUNC_XOR    = 7'h40;
  localparam func_e FUNC_SLL    = 7'h39;  // INTS
  localparam func_e FUNC_SRL    = 7'h34;

endpackage

`default_nettype wire

/* verilog/pipe_pkg.sv */
////////////////////////////////////////////////////////////
// Types internal to the pipeline. The ALU operation is
// resolved once in decode from opcode plus function code
// and carried to execute in decode_if
////////////////////////////////////////////////////////////

`default_nettype none

package pipe_pkg;

  // One entry per kept instruction
  typedef enum logic [3:0] {
    ALU_ADDQ,    // a + b mod 2^64
    ALU_SUBQ,    // a - b mod 2^64
    ALU_CMPEQ,   // 1 when equal
    ALU_CMPULT,  // 1 when a < b unsigned
    ALU_AND,
    ALU_BIS,     // Logical OR
    ALU_XOR,
    ALU_SLL,     // Shift by b[5:0]
    ALU_SRL
  } alu_op_e;

endpackage

`default_nettype wire

/* verilog/pipe_if.sv */
////////////////////////////////////////////////////////////
// Stage-to-stage bundles of the core. decode_if runs from
// decode to execute, result_if from execute to write-back.
// Forward only, nothing flows back
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none
`include "alpha_lite_settings.svh"

interface decode_if;
  logic                    valid;
  logic                    illegal;  // Unknown opcode or function
  pipe_pkg::alu_op_e       alu_op;
  logic [`ALPHA_IDX_W-1:0] ra_idx;   // Kept for forwarding compares
  logic [`ALPHA_IDX_W-1:0] rb_idx;
  logic [`ALPHA_IDX_W-1:0] rc_idx;
  logic [`ALPHA_XLEN-1:0]  ra_val;   // Register file values
  logic [`ALPHA_XLEN-1:0]  rb_val;
  logic                    use_lit;  // Operand B from lit
  logic [isa_pkg::LIT_W-1:0] lit;

  modport producer (output valid, illegal, alu_op, ra_idx, rb_idx, rc_idx,
                    output ra_val, rb_val, use_lit, lit);
  modport consumer (input valid, illegal, alu_op, ra_idx, rb_idx, rc_idx,
                    input ra_val, rb_val, use_lit, lit);
endinterface

interface result_if;
  logic                    valid;
  logic                    illegal;
  logic [`ALPHA_IDX_W-1:0] rc_idx;   // Destination
  logic [`ALPHA_XLEN-1:0]  result;

  modport producer (output valid, illegal, rc_idx, result);
  modport consumer (input valid, illegal, rc_idx, result);
endinterface

`default_nettype wire

/* verilog/inst_decode.sv */
////////////////////////////////////////////////////////////
// Decode stage. Reads ra and rb from the register file,
// resolves the ALU operation and latches everything into
// the decode/execute register one cycle after inst_valid
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none
`include "alpha_lite_settings.svh"

module inst_decode (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    inst_valid,  // Plain strobe, no handshake
  input  isa_pkg::alpha_inst_u    inst,
  output logic [`ALPHA_IDX_W-1:0] rd_idx_a,
  output logic [`ALPHA_IDX_W-1:0] rd_idx_b,
  input  logic [`ALPHA_XLEN-1:0]  rd_val_a,
  input  logic [`ALPHA_XLEN-1:0]  rd_val_b,
  decode_if.producer              dec
);

  pipe_pkg::alu_op_e alu_op;
  logic              illegal;

  // Register read addresses straight from the word
  assign rd_idx_a = inst.reg_form.ra;
  assign rd_idx_b = inst.reg_form.rb;  // Unused by ALU in literal form

  ////////////////////////////////////////////////////////////
  // Opcode and function to ALU operation
  always_comb begin
    alu_op  = pipe_pkg::ALU_ADDQ;  // Don't care when illegal
    illegal = 1'b0;
    case (inst.reg_form.opcode)
      isa_pkg::INTA: begin
        case (inst.reg_form.func)
          isa_pkg::FUNC_ADDQ:   alu_op = pipe_pkg::ALU_ADDQ;
          isa_pkg::FUNC_SUBQ:   alu_op = pipe_pkg::ALU_SUBQ;
          isa_pkg::FUNC_CMPEQ:  alu_op = pipe_pkg::ALU_CMPEQ;
          isa_pkg::FUNC_CMPULT: alu_op = pipe_pkg::ALU_CMPULT;
          default:              illegal = 1'b1;
        endcase
      end
      isa_pkg::INTL: begin
        case (inst.reg_form.func)
          isa_pkg::FUNC_AND: alu_op = pipe_pkg::ALU_AND;
          isa_pkg::FUNC_BIS: alu_op = pipe_pkg::ALU_BIS;
          isa_pkg::FUNC_XOR: alu_op = pipe_pkg::ALU_XOR;
          default:           illegal = 1'b1;
        endcase
      end
      isa_pkg::INTS: begin
        case (inst.reg_form.func)
          isa_pkg::FUNC_SLL: alu_op = pipe_pkg::ALU_SLL;
          isa_pkg::FUNC_SRL: alu_op = pipe_pkg::ALU_SRL;
          default:           illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;  // Not an operate opcode we keep
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Decode/execute register
  always_ff @(posedge clock) begin
    if (reset) begin
      dec.valid   <= 1'b0;
      dec.illegal <= 1'b0;
    end else begin
      dec.valid   <= inst_valid;
      dec.illegal <= inst_valid & illegal;
    end
  end

  // Operand and index payload
  always_ff @(posedge clock) begin
    dec.alu_op  <= alu_op;
    dec.ra_idx  <= inst.reg_form.ra;
    dec.rb_idx  <= inst.reg_form.rb;
    dec.rc_idx  <= inst.reg_form.rc;
    dec.ra_val  <= rd_val_a;
    dec.rb_val  <= rd_val_b;
    dec.use_lit <= inst.reg_form.is_lit;
    dec.lit     <= inst.lit_form.lit;  // Same bits as rb and sbz
  end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
////////////////////////////////////////////////////////////
// 32 x 64 integer register file, two read ports and one
// write port. Reads are combinational and see a same-cycle
// write. r31 reads zero and never stores
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none
`include "alpha_lite_settings.svh"

module reg_file (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [`ALPHA_IDX_W-1:0] rd_idx_a,
  input  logic [`ALPHA_IDX_W-1:0] rd_idx_b,
  output logic [`ALPHA_XLEN-1:0]  rd_val_a,
  output logic [`ALPHA_XLEN-1:0]  rd_val_b,
  input  logic                    wr_en,
  input  logic [`ALPHA_IDX_W-1:0] wr_idx,
  input  logic [`ALPHA_XLEN-1:0]  wr_data
);

  localparam logic [`ALPHA_IDX_W-1:0] ZERO_IDX = `ALPHA_ZERO_REG;

  logic [`ALPHA_XLEN-1:0] regs [`ALPHA_NUM_REGS];

  // Zero reg first, then write-through, then storage
  function automatic logic [`ALPHA_XLEN-1:0] read_port(
    input logic [`ALPHA_IDX_W-1:0] idx
  );
    if (idx == ZERO_IDX) return '0;
    if (wr_en && (wr_idx == idx)) return wr_data;  // Bypass write-back
    return regs[idx];
  endfunction

  always_comb begin
    rd_val_a = read_port(rd_idx_a);
    rd_val_b = read_port(rd_idx_b);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `ALPHA_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != ZERO_IDX)) begin
      regs[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* verilog/alu_execute.sv */
////////////////////////////////////////////////////////////
// Execute stage. Forwards from its own output register,
// picks the literal for operand B when asked, runs the ALU
// and holds the result for write-back one cycle later
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none
`include "alpha_lite_settings.svh"

module alu_execute (
  input  logic        clock,
  input  logic        reset,
  decode_if.consumer  dec,
  result_if.producer  res
);

  localparam int SHAMT_W = $clog2(`ALPHA_XLEN);  // 6 for 64-bit shifts
  localparam logic [`ALPHA_IDX_W-1:0] ZERO_IDX = `ALPHA_ZERO_REG;

  logic                    ex_valid;    // Execute/write-back register
  logic                    ex_illegal;
  logic [`ALPHA_IDX_W-1:0] ex_rc_idx;
  logic [`ALPHA_XLEN-1:0]  ex_result;
  logic                    fwd_ok;
  logic [`ALPHA_XLEN-1:0]  opa;
  logic [`ALPHA_XLEN-1:0]  opb;
  logic [`ALPHA_XLEN-1:0]  alu_out;

  ////////////////////////////////////////////////////////////
  // Operand forwarding, distance one
  // Farther producers are covered by the register file bypass
  assign fwd_ok = ex_valid & ~ex_illegal & (ex_rc_idx != ZERO_IDX);

  assign opa = (fwd_ok && (dec.ra_idx == ex_rc_idx)) ? ex_result : dec.ra_val;

  always_comb begin
    if (dec.use_lit) begin
      opb = {{(`ALPHA_XLEN - isa_pkg::LIT_W){1'b0}}, dec.lit};  // Zero-extend
    end else if (fwd_ok && (dec.rb_idx == ex_rc_idx)) begin
      opb = ex_result;
    end else begin
      opb = dec.rb_val;
    end
  end

  ////////////////////////////////////////////////////////////
  // ALU
  always_comb begin
    case (dec.alu_op)
      pipe_pkg::ALU_ADDQ:   alu_out = opa + opb;  // Wraps mod 2^64
      pipe_pkg::ALU_SUBQ:   alu_out = opa - opb;
      pipe_pkg::ALU_CMPEQ:  alu_out = {{(`ALPHA_XLEN - 1){1'b0}}, opa == opb};
      pipe_pkg::ALU_CMPULT: alu_out = {{(`ALPHA_XLEN - 1){1'b0}}, opa < opb};
      pipe_pkg::ALU_AND:    alu_out = opa & opb;
      pipe_pkg::ALU_BIS:    alu_out = opa | opb;
      pipe_pkg::ALU_XOR:    alu_out = opa ^ opb;
      pipe_pkg::ALU_SLL:    alu_out = opa << opb[SHAMT_W-1:0];
      pipe_pkg::ALU_SRL:    alu_out = opa >> opb[SHAMT_W-1:0];  // Logical
      default:              alu_out = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid   <= 1'b0;
      ex_illegal <= 1'b0;
    end else begin
      ex_valid   <= dec.valid;
      ex_illegal <= dec.illegal;
    end
  end

  always_ff @(posedge clock) begin
    ex_rc_idx <= dec.rc_idx;
    ex_result <= alu_out;
  end

  assign res.valid   = ex_valid;
  assign res.illegal = ex_illegal;
  assign res.rc_idx  = ex_rc_idx;
  assign res.result  = ex_result;

endmodule

`default_nettype wire

/* verilog/write_back.sv */
////////////////////////////////////////////////////////////
// Write-back stage. One decision drives both the register
// file write and the commit port. Purely combinational
// from the execute/write-back register
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none
`include "alpha_lite_settings.svh"

module write_back (
  result_if.consumer              res,
  output logic                    wr_en,
  output logic [`ALPHA_IDX_W-1:0] wr_idx,
  output logic [`ALPHA_XLEN-1:0]  wr_data,
  output logic                    commit_valid,
  output logic                    commit_wr_en,
  output logic                    commit_illegal,
  output logic [`ALPHA_IDX_W-1:0] commit_idx,
  output logic [`ALPHA_XLEN-1:0]  commit_data
);

  localparam logic [`ALPHA_IDX_W-1:0] ZERO_IDX = `ALPHA_ZERO_REG;

  logic do_write;  // Valid, legal, not r31
  logic legal;

  assign legal    = res.valid & ~res.illegal;
  assign do_write = legal & (res.rc_idx != ZERO_IDX);

  // Register file port
  assign wr_en   = do_write;
  assign wr_idx  = res.rc_idx;
  assign wr_data = res.result;

  // Commit port
  assign commit_valid   = res.valid;
  assign commit_wr_en   = do_write;
  assign commit_illegal = res.valid & res.illegal;
  assign commit_idx     = res.rc_idx;
  assign commit_data    = legal ? res.result : '0;  // Zero for illegal

endmodule

`default_nettype wire

/* verilog/alpha_lite_top.sv */
////////////////////////////////////////////////////////////
// Top level of the three-stage Alpha operate core.
// One instruction per inst_valid strobe, committed two
// edges later on the commit port
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none
`include "alpha_lite_settings.svh"

module alpha_lite_top (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    inst_valid,
  input  logic [`ALPHA_INST_W-1:0] inst,
  output logic                    commit_valid,
  output logic                    commit_wr_en,
  output logic [`ALPHA_IDX_W-1:0] commit_idx,
  output logic [`ALPHA_XLEN-1:0]  commit_data,
  output logic                    commit_illegal
);

  logic [`ALPHA_IDX_W-1:0] rd_idx_a;  // Decode to register file
  logic [`ALPHA_IDX_W-1:0] rd_idx_b;
  logic [`ALPHA_XLEN-1:0]  rd_val_a;
  logic [`ALPHA_XLEN-1:0]  rd_val_b;
  logic                    wr_en;     // Write-back to register file
  logic [`ALPHA_IDX_W-1:0] wr_idx;
  logic [`ALPHA_XLEN-1:0]  wr_data;

  decode_if dec_if ();
  result_if res_if ();

  inst_decode u_decode (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rd_idx_a   (rd_idx_a),
    .rd_idx_b   (rd_idx_b),
    .rd_val_a   (rd_val_a),
    .rd_val_b   (rd_val_b),
    .dec        (dec_if.producer)
  );

  reg_file u_regs (
    .clock    (clock),
    .reset    (reset),
    .rd_idx_a (rd_idx_a),
    .rd_idx_b (rd_idx_b),
    .rd_val_a (rd_val_a),
    .rd_val_b (rd_val_b),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_data  (wr_data)
  );

  alu_execute u_execute (
    .clock (clock),
    .reset (reset),
    .dec   (dec_if.consumer),
    .res   (res_if.producer)
  );

  write_back u_write_back (
    .res            (res_if.consumer),
    .wr_en          (wr_en),
    .wr_idx         (wr_idx),
    .wr_data        (wr_data),
    .commit_valid   (commit_valid),
    .commit_wr_en   (commit_wr_en),
    .commit_illegal (commit_illegal),
    .commit_idx     (commit_idx),
    .commit_data    (commit_data)
  );

endmodule

`default_nettype wire

/* verif/tb_alpha_lite.sv */
////////////////////////////////////////////////////////////
// Self-checking testbench for the three-stage Alpha core.
// A table of instructions and expected commits is built at
// time zero, then driven one row per cycle. Each row is
// checked on the commit port two edges after it is sampled
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none
`include "alpha_lite_settings.svh"

module tb_alpha_lite;

  localparam int DRIVE_DLY = 2;   // ns after the rising edge
  localparam int LATENCY   = 2;   // Edges from sample to commit
  localparam int DRAIN_MAX = 10;  // Cycles allowed to go quiet

  // Operate opcodes and function codes, from the ISA
  localparam logic [5:0] OP_INTA  = 6'h10;
  localparam logic [5:0] OP_INTL  = 6'h11;
  localparam logic [5:0] OP_INTS  = 6'h12;
  localparam logic [6:0] F_ADDQ   = 7'h20;
  localparam logic [6:0] F_SUBQ   = 7'h29;
  localparam logic [6:0] F_CMPEQ  = 7'h2d;
  localparam logic [6:0] F_CMPULT = 7'h1d;
  localparam logic [6:0] F_AND    = 7'h00;
  localparam logic [6:0] F_BIS    = 7'h20;
  localparam logic [6:0] F_XOR    = 7'h40;
  localparam logic [6:0] F_SLL    = 7'h39;
  localparam logic [6:0] F_SRL    = 7'h34;

  // One table row, stimulus then expected commit
  typedef struct packed {
    logic                     in_valid;
    logic [`ALPHA_INST_W-1:0] word;
    logic                     exp_valid;
    logic                     exp_wr_en;
    logic [`ALPHA_IDX_W-1:0]  exp_idx;
    logic [`ALPHA_XLEN-1:0]   exp_data;
    logic                     exp_illegal;
  } row_t;

  logic                     clock;
  logic                     reset;
  logic                     inst_valid;
  logic [`ALPHA_INST_W-1:0] inst;
  logic                     commit_valid;
  logic                     commit_wr_en;
  logic [`ALPHA_IDX_W-1:0]  commit_idx;
  logic [`ALPHA_XLEN-1:0]   commit_data;
  logic                     commit_illegal;

  row_t rows[$];

  alpha_lite_top UUT (
    .clock          (clock),
    .reset          (reset),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .commit_valid   (commit_valid),
    .commit_wr_en   (commit_wr_en),
    .commit_idx     (commit_idx),
    .commit_data    (commit_data),
    .commit_illegal (commit_illegal)
  );

  always #20 clock = ~clock;  // 40 ns period

  ////////////////////////////////////////////////////////////
  // Instruction encoders
  function automatic logic [`ALPHA_INST_W-1:0] encode_reg_form(
    input logic [5:0] opcode, input logic [6:0] func,
    input logic [4:0] ra, input logic [4:0] rb, input logic [4:0] rc
  );
    return {opcode, ra, rb, 3'b000, 1'b0, func, rc};  // sbz kept zero
  endfunction

  function automatic logic [`ALPHA_INST_W-1:0] encode_lit_form(
    input logic [5:0] opcode, input logic [6:0] func,
    input logic [4:0] ra, input logic [7:0] lit, input logic [4:0] rc
  );
    return {opcode, ra, lit, 1'b1, func, rc};
  endfunction

  // Table builders
  task automatic expect_commit(input logic [`ALPHA_INST_W-1:0] word, input logic wr_en,
                               input logic [4:0] idx, input logic [`ALPHA_XLEN-1:0] data);
    rows.push_back({1'b1, word, 1'b1, wr_en, idx, data, 1'b0});
  endtask

  task automatic expect_illegal(input logic [`ALPHA_INST_W-1:0] word, input logic [4:0] idx);
    rows.push_back({1'b1, word, 1'b1, 1'b0, idx, 64'h0, 1'b1});  // No write, data zero
  endtask

  task automatic insert_gap();
    logic [`ALPHA_INST_W-1:0] word;
    word = encode_lit_form(OP_INTA, F_ADDQ, 5'd31, 8'hee, 5'd17);  // Would clobber r17
    rows.push_back({1'b0, word, 1'b0, 1'b0, 5'd0, 64'h0, 1'b0});
  endtask

  ////////////////////////////////////////////////////////////
  // Program, expected values from a sequential reading
  task automatic build_program();
    insert_gap();  // Commit port idle out of reset
    insert_gap();
    expect_commit(encode_reg_form(OP_INTA, F_ADDQ, 5'd1, 5'd2, 5'd3), 1'b1, 5'd3, 64'h0);
    // Literal constants
    expect_commit(encode_lit_form(OP_INTA, F_ADDQ, 5'd31, 8'h7f, 5'd1), 1'b1, 5'd1, 64'h7f);
    expect_commit(encode_lit_form(OP_INTL, F_BIS, 5'd31, 8'ha5, 5'd2), 1'b1, 5'd2, 64'ha5);
    expect_commit(encode_lit_form(OP_INTL, F_XOR, 5'd1, 8'hff, 5'd4), 1'b1, 5'd4, 64'h80);
    expect_commit(encode_lit_form(OP_INTS, F_SLL, 5'd2, 8'd56, 5'd5), 1'b1, 5'd5,
                  64'ha500_0000_0000_0000);  // Wide value
    expect_commit(encode_reg_form(OP_INTL, F_BIS, 5'd5, 5'd1, 5'd6), 1'b1, 5'd6,
                  64'ha500_0000_0000_007f);
    // Dependency chain, distances 1 to 3
    expect_commit(encode_reg_form(OP_INTA, F_SUBQ, 5'd1, 5'd2, 5'd7), 1'b1, 5'd7,
                  64'hffff_ffff_ffff_ffda);  // 0x7f - 0xa5 wraps
    expect_commit(encode_reg_form(OP_INTL, F_AND, 5'd7, 5'd6, 5'd8), 1'b1, 5'd8,
                  64'ha500_0000_0000_005a);
    expect_commit(encode_lit_form(OP_INTS, F_SRL, 5'd8, 8'd4, 5'd9), 1'b1, 5'd9,
                  64'h0a50_0000_0000_0005);
    expect_commit(encode_reg_form(OP_INTA, F_CMPEQ, 5'd8, 5'd7, 5'd10), 1'b1, 5'd10, 64'h0);
    expect_commit(encode_reg_form(OP_INTA, F_CMPULT, 5'd9, 5'd8, 5'd11), 1'b1, 5'd11,
                  64'h1);  // Unsigned, signed would give 0
    expect_commit(encode_lit_form(OP_INTA, F_CMPEQ, 5'd11, 8'h01, 5'd12), 1'b1, 5'd12, 64'h1);
    expect_commit(encode_reg_form(OP_INTA, F_SUBQ, 5'd31, 5'd12, 5'd13), 1'b1, 5'd13,
                  64'hffff_ffff_ffff_ffff);
    // r31 as target and source
    expect_commit(encode_lit_form(OP_INTA, F_ADDQ, 5'd1, 8'h05, 5'd31), 1'b0, 5'd31, 64'h84);
    expect_commit(encode_reg_form(OP_INTA, F_ADDQ, 5'd31, 5'd1, 5'd14), 1'b1, 5'd14, 64'h7f);
    expect_commit(encode_reg_form(OP_INTL, F_BIS, 5'd1, 5'd31, 5'd15), 1'b1, 5'd15, 64'h7f);
    // Illegal words leave r1 and r2 alone
    expect_illegal(encode_reg_form(6'h3f, F_ADDQ, 5'd1, 5'd2, 5'd1), 5'd1);
    expect_illegal(encode_reg_form(OP_INTA, 7'h7f, 5'd1, 5'd2, 5'd2), 5'd2);
    expect_commit(encode_reg_form(OP_INTA, F_ADDQ, 5'd1, 5'd2, 5'd16), 1'b1, 5'd16, 64'h124);
    // Forwarding across idle gaps
    expect_commit(encode_lit_form(OP_INTA, F_SUBQ, 5'd16, 8'h24, 5'd17), 1'b1, 5'd17, 64'h100);
    insert_gap();
    expect_commit(encode_reg_form(OP_INTA, F_ADDQ, 5'd17, 5'd16, 5'd18), 1'b1, 5'd18, 64'h224);
    insert_gap();
    insert_gap();
    expect_commit(encode_reg_form(OP_INTS, F_SLL, 5'd18, 5'd17, 5'd19), 1'b1, 5'd19,
                  64'h224);  // Low 6 bits of 0x100 are zero
    insert_gap();
    expect_commit(encode_reg_form(OP_INTL, F_XOR, 5'd19, 5'd6, 5'd20), 1'b1, 5'd20,
                  64'ha500_0000_0000_025b);
    insert_gap();
    insert_gap();
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  task automatic check_field(input string tag, input string field,
                             input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s %s is %h, expected %h",
               $time, tag, field, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "commit port check failed");
    end
  endtask

  task automatic check_commit(input int row);
    string tag;
    row_t  r;
    r   = rows[row];
    tag = $sformatf("row %0d", row);
    check_field(tag, "commit_valid", 64'(commit_valid), 64'(r.exp_valid));
    check_field(tag, "commit_wr_en", 64'(commit_wr_en), 64'(r.exp_wr_en));
    check_field(tag, "commit_illegal", 64'(commit_illegal), 64'(r.exp_illegal));
    if (r.exp_valid) begin  // Index and data only mean something on a commit
      check_field(tag, "commit_idx", 64'(commit_idx), 64'(r.exp_idx));
      check_field(tag, "commit_data", commit_data, r.exp_data);
    end
  endtask

  // Commit port before the first row arrives
  task automatic check_quiet();
    check_field("after reset", "commit_valid", 64'(commit_valid), 64'h0);
    check_field("after reset", "commit_wr_en", 64'(commit_wr_en), 64'h0);
    check_field("after reset", "commit_illegal", 64'(commit_illegal), 64'h0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  initial begin
    int n;
    int drain;
    clock      = 1'b0;
    reset      = 1'b1;
    inst_valid = 1'b1;  // Legal write held through reset, never commits
    inst       = encode_lit_form(OP_INTA, F_ADDQ, 5'd31, 8'h5a, 5'd3);
    build_program();
    n = rows.size();

    repeat (3) @(posedge clock);  // Reset held 3 cycles
    #DRIVE_DLY;
    reset = 1'b0;

    for (int i = 0; i < n + LATENCY; i++) begin
      if (i >= LATENCY) begin
        check_commit(i - LATENCY);  // Row sampled two edges ago
      end else begin
        check_quiet();  // Still what reset left behind
      end
      if (i < n) begin
        inst_valid = rows[i].in_valid;
        inst       = rows[i].word;
      end else begin
        inst_valid = 1'b0;
        inst       = '0;
      end
      @(posedge clock);
      #DRIVE_DLY;
    end

    // Pipeline must go quiet
    drain = 0;
    while (commit_valid && (drain < DRAIN_MAX)) begin
      @(posedge clock);
      #DRIVE_DLY;
      drain++;
    end
    if (commit_valid) begin
      $display("timeout: commit_valid still high %0d cycles after the last row", DRAIN_MAX);
      $display("STATUS: FAIL");
      $fatal(1, "drain timeout");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* alpha_lite_top.f */
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/pipe_if.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/alu_execute.sv
verilog/write_back.sv
verilog/alpha_lite_top.sv
verif/tb_alpha_lite.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the Alpha subset core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f alpha_lite_top.f \
  --top-module tb_alpha_lite \
  -o sim_alpha_lite

# Run log is kept for the result search below
./obj_dir/sim_alpha_lite > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
